// ==== husky_pkg.sv ====
`default_nettype none

package husky_pkg;

   // register bus widths
   localparam int BYTECNT_W = 7;                 // byte index within one access
   localparam int ADDR_W    = 8;
   localparam int DATA_W    = 8;

   // adc serial port
   localparam int ADC_FRAME_BITS = 16;           // address byte then data byte
   localparam int ADC_BITCNT_W   = $clog2(ADC_FRAME_BITS);
   localparam int ADC_RB_W       = 8;            // readback keeps the last byte

   // register map
   typedef enum logic [ADDR_W-1:0] {
      ADDR_TRIG_SRC   = 8'h20,                   // io enable mask [3:0]
      ADDR_TRIG_MODE  = 8'h21,                   // [0] and/or, [1] invert
      ADDR_TRIG_COUNT = 8'h22,                   // event count, write clears
      ADDR_ADC_CTRL   = 8'h30,                   // reset, oe, dfs
      ADDR_ADC_SPI    = 8'h31,                   // byte 0 addr, byte 1 data
      ADDR_ADC_STATUS = 8'h32                    // [0] busy, read only
   } reg_addr_e;

   // internal register bus, one driver and many listeners
   typedef struct packed {
      logic [ADDR_W-1:0]    address;
      logic [BYTECNT_W-1:0] bytecnt;
      logic [DATA_W-1:0]    wdata;
      logic                 read;                // level, follows the strobe
      logic                 write;               // single cycle pulse
      logic                 addrvalid;
   } reg_bus_t;

   // adc serial shifter states
   typedef enum logic [1:0] {
      IDLE  = 2'd0,
      SHIFT = 2'd1,                              // sclk running, sen low
      DONE  = 2'd2                               // readback latched here
   } adc_spi_state_e;

endpackage

`default_nettype wire

// ==== usb_reg_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_reg_bus (
   input  logic                clk_usb_buf,
   input  logic                arst_n_i,
   input  logic [7:0]          usb_addr_i,
   input  logic [7:0]          usb_data_i,
   input  logic                usb_alen_i,   // active low address latch
   input  logic                usb_cen_i,    // active low chip enable
   input  logic                usb_rdn_i,
   input  logic                usb_wrn_i,
   output logic [7:0]          usb_data_o,
   output logic                usb_data_oe_o,
   output husky_pkg::reg_bus_t reg_bus_o,
   input  logic [7:0]          rdata_i       // already ORed over all blocks
);
   import husky_pkg::*;

   logic [ADDR_W-1:0]    addr_r;       // latched during alen low
   logic [BYTECNT_W-1:0] bytecnt_r;
   logic [DATA_W-1:0]    wdata_r;
   logic                 addrvalid_r;
   logic                 write_r;      // the one-cycle write pulse
   logic                 wrn_q;        // previous wrn for edge detect
   logic                 rd_q;         // previous read level
   logic                 rd_lvl;
   logic                 wr_fall;
   logic                 rd_end;

   // host bus decode
   assign rd_lvl  = ~usb_cen_i & ~usb_rdn_i;              // read follows strobe
   assign wr_fall = wrn_q & ~usb_wrn_i & ~usb_cen_i;      // falling wrn, chip selected
   assign rd_end  = rd_q & ~rd_lvl;                       // rdn went back high

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wrn_q       <= 1'b1;
         rd_q        <= 1'b0;
         write_r     <= 1'b0;
         addrvalid_r <= 1'b0;
         bytecnt_r   <= '0;
      end else begin
         wrn_q   <= usb_wrn_i;
         rd_q    <= rd_lvl;
         write_r <= wr_fall;                              // pulse one clock after edge

         if (!usb_alen_i) begin
            addrvalid_r <= 1'b1;                          // holds until next address cycle
         end

         // byte counter within one access
         if (!usb_alen_i) begin
            bytecnt_r <= '0;
         end else if (write_r || rd_end) begin
            bytecnt_r <= bytecnt_r + 1'b1;                // moves after the byte is done
         end
      end
   end

   // address latch and write data capture
   always_ff @(posedge clk_usb_buf) begin
      if (!usb_alen_i) begin
         addr_r <= usb_addr_i;                            // every clock while alen low
      end
      if (wr_fall) begin
         wdata_r <= usb_data_i;                           // sampled at the strobe edge
      end
   end

   // read data back to host
   // second stage after the registered block rdata
   always_ff @(posedge clk_usb_buf) begin
      usb_data_o <= rdata_i;
   end

   assign usb_data_oe_o = rd_lvl;                         // drive only during a read

   // register bus out
   assign reg_bus_o = '{
      address:   addr_r,
      bytecnt:   bytecnt_r,
      wdata:     wdata_r,
      read:      rd_lvl,
      write:     write_r,
      addrvalid: addrvalid_r
   };

endmodule

`default_nettype wire

// ==== reg_trigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_trigger (
   input  logic                clk_usb_buf,
   input  logic                arst_n_i,
   input  husky_pkg::reg_bus_t reg_bus_i,
   output logic [7:0]          rdata_o,
   input  logic [3:0]          target_io_i,   // io1 in bit 0
   output logic                trigger_o
);
   import husky_pkg::*;

   reg_addr_e  addr;
   logic [3:0] mask_r;        // which io lines take part
   logic [1:0] mode_r;        // [0] and, [1] invert
   logic [7:0] count_r;       // wraps
   logic       trig_q;        // previous trigger for edge detect
   logic [3:0] sel;
   logic       or_v;
   logic       and_v;
   logic       raw;
   logic       trig_next;
   logic       wr_src;
   logic       wr_mode;
   logic       wr_count;
   logic       trig_rise;

   assign addr = reg_addr_e'(reg_bus_i.address);

   // write decode
   assign wr_src   = reg_bus_i.write & reg_bus_i.addrvalid & (addr == ADDR_TRIG_SRC);
   assign wr_mode  = reg_bus_i.write & reg_bus_i.addrvalid & (addr == ADDR_TRIG_MODE);
   assign wr_count = reg_bus_i.write & reg_bus_i.addrvalid & (addr == ADDR_TRIG_COUNT);

   // combine the enabled lines
   assign sel       = target_io_i & mask_r;
   assign or_v      = |sel;
   assign and_v     = (|mask_r) & (&(target_io_i | ~mask_r));  // empty mask gives 0
   assign raw       = mode_r[0] ? and_v : or_v;
   assign trig_next = raw ^ mode_r[1];                          // invert applied last

   assign trig_rise = trigger_o & ~trig_q;

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mask_r    <= '0;
         mode_r    <= '0;
         count_r   <= '0;
         trigger_o <= 1'b0;
         trig_q    <= 1'b0;
      end else begin
         if (wr_src) begin
            mask_r <= reg_bus_i.wdata[3:0];
         end
         if (wr_mode) begin
            mode_r <= reg_bus_i.wdata[1:0];
         end

         trigger_o <= trig_next;           // one cycle behind the io lines
         trig_q    <= trigger_o;

         // any written value clears, clear wins over a coincident edge
         if (wr_count) begin
            count_r <= '0;
         end else if (trig_rise) begin
            count_r <= count_r + 8'd1;
         end
      end
   end

   // read mux, registered while read is high
   always_ff @(posedge clk_usb_buf) begin
      if (reg_bus_i.read && reg_bus_i.addrvalid) begin
         case (addr)
            ADDR_TRIG_SRC:   rdata_o <= {4'b0, mask_r};
            ADDR_TRIG_MODE:  rdata_o <= {6'b0, mode_r};
            ADDR_TRIG_COUNT: rdata_o <= count_r;
            default:         rdata_o <= '0;          // not ours
         endcase
      end else begin
         rdata_o <= '0;                              // keeps the OR clean
      end
   end

endmodule

`default_nettype wire

// ==== reg_adc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_adc_ctrl (
   input  logic                clk_usb_buf,
   input  logic                arst_n_i,
   input  husky_pkg::reg_bus_t reg_bus_i,
   output logic [7:0]          rdata_o,
   output logic                adc_sclk_o,
   output logic                adc_sdata_o,
   output logic                adc_sen_o,     // active low frame enable
   input  logic                adc_sdout_i,
   output logic                adc_reset_o,
   output logic                adc_oe_o,
   output logic                adc_dfs_o
);
   import husky_pkg::*;

   reg_addr_e                 addr;
   adc_spi_state_e            state_r;
   logic [2:0]                ctrl_r;        // dfs, oe, reset
   logic [7:0]                spi_addr_r;    // byte 0 of the frame
   logic [ADC_FRAME_BITS-1:0] shreg_r;       // outgoing, msb first
   logic [ADC_RB_W-1:0]       shin_r;        // incoming sdout bits
   logic [ADC_RB_W-1:0]       rb_r;          // last readback byte
   logic [ADC_BITCNT_W-1:0]   bit_cnt_r;     // counts falling sclk
   logic                      busy;
   logic                      wr_ctrl;
   logic                      wr_spi0;
   logic                      wr_spi1;
   logic                      start;

   assign addr = reg_addr_e'(reg_bus_i.address);
   assign busy = (state_r == SHIFT);

   // write decode, bytecnt picks the byte of ADC_SPI
   assign wr_ctrl = reg_bus_i.write & reg_bus_i.addrvalid & (addr == ADDR_ADC_CTRL);
   assign wr_spi0 = reg_bus_i.write & reg_bus_i.addrvalid & (addr == ADDR_ADC_SPI)
                    & (reg_bus_i.bytecnt == '0);
   assign wr_spi1 = reg_bus_i.write & reg_bus_i.addrvalid & (addr == ADDR_ADC_SPI)
                    & (reg_bus_i.bytecnt == BYTECNT_W'(1));
   assign start   = wr_spi1 & ~busy;                   // ignored mid-frame

   assign {adc_dfs_o, adc_oe_o, adc_reset_o} = ctrl_r;
   assign adc_sdata_o = shreg_r[ADC_FRAME_BITS-1];

   always_ff @(posedge clk_usb_buf or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_r    <= IDLE;
         ctrl_r     <= '0;
         spi_addr_r <= '0;
         shreg_r    <= '0;
         bit_cnt_r  <= '0;
         rb_r       <= '0;
         adc_sclk_o <= 1'b0;
         adc_sen_o  <= 1'b1;
      end else begin
         if (wr_ctrl) begin
            ctrl_r <= reg_bus_i.wdata[2:0];            // pins follow one cycle later
         end
         if (wr_spi0 && !busy) begin
            spi_addr_r <= reg_bus_i.wdata;
         end

         case (state_r)
            IDLE, DONE: begin
               if (state_r == DONE) begin
                  rb_r <= shin_r;                      // frame finished
               end
               state_r <= IDLE;
               if (start) begin
                  state_r    <= SHIFT;
                  adc_sen_o  <= 1'b0;
                  adc_sclk_o <= 1'b0;
                  bit_cnt_r  <= '0;
                  shreg_r    <= {spi_addr_r, reg_bus_i.wdata};
               end
            end
            SHIFT: begin
               adc_sclk_o <= ~adc_sclk_o;              // half period is one clock
               if (adc_sclk_o) begin                   // falling sclk
                  shreg_r <= {shreg_r[ADC_FRAME_BITS-2:0], 1'b0};
                  if (bit_cnt_r == ADC_BITCNT_W'(ADC_FRAME_BITS - 1)) begin
                     state_r   <= DONE;
                     adc_sen_o <= 1'b1;
                  end else begin
                     bit_cnt_r <= bit_cnt_r + 1'b1;
                  end
               end
            end
            default: state_r <= IDLE;
         endcase
      end
   end

   // sdout sampled on rising sclk, the last 8 bits survive
   always_ff @(posedge clk_usb_buf) begin
      if (state_r == SHIFT && !adc_sclk_o) begin
         shin_r <= {shin_r[ADC_RB_W-2:0], adc_sdout_i};
      end
   end

   // read mux
   always_ff @(posedge clk_usb_buf) begin
      if (reg_bus_i.read && reg_bus_i.addrvalid) begin
         case (addr)
            ADDR_ADC_CTRL:   rdata_o <= {5'b0, ctrl_r};
            ADDR_ADC_SPI:    rdata_o <= rb_r;
            ADDR_ADC_STATUS: rdata_o <= {7'b0, busy};
            default:         rdata_o <= '0;
         endcase
      end else begin
         rdata_o <= '0;
      end
   end

endmodule

`default_nettype wire

// ==== husky_regs_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module husky_regs_top (
   input  logic       clk_usb_buf,
   input  logic       arst_n_i,
   // host parallel bus
   input  logic [7:0] usb_addr_i,
   input  logic [7:0] usb_data_i,
   input  logic       usb_alen_i,
   input  logic       usb_cen_i,
   input  logic       usb_rdn_i,
   input  logic       usb_wrn_i,
   output logic [7:0] usb_data_o,
   output logic       usb_data_oe_o,
   // target io and trigger
   input  logic [3:0] target_io_i,
   output logic       trigger_o,
   // adc pins
   output logic       adc_sclk_o,
   output logic       adc_sdata_o,
   output logic       adc_sen_o,
   input  logic       adc_sdout_i,
   output logic       adc_reset_o,
   output logic       adc_oe_o,
   output logic       adc_dfs_o
);
   import husky_pkg::*;

   reg_bus_t   reg_bus;
   logic [7:0] rdata_trig;
   logic [7:0] rdata_adc;
   logic [7:0] rdata;

   assign rdata = rdata_trig | rdata_adc;    // idle blocks return zero

   usb_reg_bus usb_reg_bus_i (
      .clk_usb_buf   (clk_usb_buf),
      .arst_n_i      (arst_n_i),
      .usb_addr_i    (usb_addr_i),
      .usb_data_i    (usb_data_i),
      .usb_alen_i    (usb_alen_i),
      .usb_cen_i     (usb_cen_i),
      .usb_rdn_i     (usb_rdn_i),
      .usb_wrn_i     (usb_wrn_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_bus_o     (reg_bus),
      .rdata_i       (rdata)
   );

   reg_trigger reg_trigger_i (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .reg_bus_i   (reg_bus),
      .rdata_o     (rdata_trig),
      .target_io_i (target_io_i),
      .trigger_o   (trigger_o)
   );

   reg_adc_ctrl reg_adc_ctrl_i (
      .clk_usb_buf (clk_usb_buf),
      .arst_n_i    (arst_n_i),
      .reg_bus_i   (reg_bus),
      .rdata_o     (rdata_adc),
      .adc_sclk_o  (adc_sclk_o),
      .adc_sdata_o (adc_sdata_o),
      .adc_sen_o   (adc_sen_o),
      .adc_sdout_i (adc_sdout_i),
      .adc_reset_o (adc_reset_o),
      .adc_oe_o    (adc_oe_o),
      .adc_dfs_o   (adc_dfs_o)
   );

endmodule

`default_nettype wire

// ==== tb_usb_host.svh ====
`ifndef TB_USB_HOST_SVH
`define TB_USB_HOST_SVH

// compare one value, report and count a mismatch
task automatic expect_equal(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
   checks++;
   if (got !== exp) begin
      mismatches++;
      $display("Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
   end
endtask

// a wait loop ran out
task automatic note_timeout(input string what);
   failures++;
   $display("Timeout at %0t ns: %s", $time, what);
endtask

// address cycle, alen low for 3 clocks then high for 2
task automatic usb_address(input logic [7:0] addr);
   @(posedge clk_usb_buf);
   usb_addr_i <= addr;
   usb_alen_i <= 1'b0;
   repeat (3) @(posedge clk_usb_buf);
   usb_alen_i <= 1'b1;
   repeat (2) @(posedge clk_usb_buf);
endtask

// byte 0 sits in data[7:0], byte 1 in data[15:8]
task automatic usb_write(input logic [7:0] addr, input int nbytes, input logic [15:0] data);
   logic [15:0] left;
   left = data;
   usb_address(addr);
   @(posedge clk_usb_buf);
   usb_cen_i <= 1'b0;                      // chip selected for the whole access
   for (int i = 0; i < nbytes; i++) begin
      @(posedge clk_usb_buf);
      usb_data_i <= left[7:0];             // data valid with the falling strobe
      usb_wrn_i  <= 1'b0;
      left = left >> 8;
      repeat (3) @(posedge clk_usb_buf);
      usb_wrn_i <= 1'b1;
      @(posedge clk_usb_buf);
   end
   usb_cen_i <= 1'b1;
endtask

// last byte read ends up in data[7:0]
task automatic usb_read(input logic [7:0] addr, input int nbytes, output logic [15:0] data);
   data = '0;
   usb_address(addr);
   @(posedge clk_usb_buf);
   usb_cen_i <= 1'b0;
   for (int i = 0; i < nbytes; i++) begin
      @(posedge clk_usb_buf);
      usb_rdn_i <= 1'b0;
      repeat (2) @(posedge clk_usb_buf);
      @(negedge clk_usb_buf);
      data = {data[7:0], usb_data_o};      // two register stages after rdn falls
      expect_equal("usb_data_oe_o", 16'(usb_data_oe_o), 16'h1);
      @(posedge clk_usb_buf);
      usb_rdn_i <= 1'b1;
      @(negedge clk_usb_buf);
      expect_equal("usb_data_oe_o", 16'(usb_data_oe_o), 16'h0);  // released with rdn
      @(posedge clk_usb_buf);
   end
   usb_cen_i <= 1'b1;
endtask

// write a random byte, read it back through the register mask
task automatic roundtrip_register(input logic [7:0] addr, input string name,
                                  input logic [7:0] keep, output logic [7:0] val);
   int          rnd;
   logic [15:0] rd;
   rnd = $random(seed);
   val = rnd[7:0];
   usb_write(addr, 1, {8'h00, val});
   usb_read(addr, 1, rd);
   expect_equal(name, rd, {8'h00, val & keep});
endtask

`endif

// ==== tb_husky_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_husky_regs;
   import husky_pkg::*;

   logic       clk_usb_buf;
   logic       arst_n_i;
   logic [7:0] usb_addr_i;
   logic [7:0] usb_data_i;
   logic       usb_alen_i;
   logic       usb_cen_i;
   logic       usb_rdn_i;
   logic       usb_wrn_i;
   logic [7:0] usb_data_o;
   logic       usb_data_oe_o;
   logic [3:0] target_io_i;
   logic       trigger_o;
   logic       adc_sclk_o;
   logic       adc_sdata_o;
   logic       adc_sen_o;
   logic       adc_sdout_i;
   logic       adc_reset_o;
   logic       adc_oe_o;
   logic       adc_dfs_o;
   int         seed = 27943;
   int         checks;
   int         mismatches;
   int         failures;

   `include "tb_usb_host.svh"

   husky_regs_top husky_regs_top_i (.*);

   always #2 clk_usb_buf = ~clk_usb_buf;     // 4 ns period

   // expected trigger with the invert applied last
   function automatic logic trig_model(input logic [3:0] io, input logic [3:0] mask,
                                       input logic [1:0] mode);
      logic any_on;
      logic all_on;
      logic res;
      any_on = ((io & mask) != 4'h0);
      all_on = (mask != 4'h0) && ((io & mask) == mask);   // empty mask gives 0
      res    = mode[0] ? all_on : any_on;
      return mode[1] ? !res : res;
   endfunction

   task automatic check_reset_state();
      logic [15:0] rd;
      @(negedge clk_usb_buf);
      expect_equal("usb_data_oe_o", 16'(usb_data_oe_o), 16'h0);
      expect_equal("trigger_o", 16'(trigger_o), 16'h0);
      expect_equal("adc_sen_o", 16'(adc_sen_o), 16'h1);
      expect_equal("adc_sclk_o", 16'(adc_sclk_o), 16'h0);
      expect_equal("adc ctrl pins", 16'({adc_dfs_o, adc_oe_o, adc_reset_o}), 16'h0);
      usb_read(ADDR_TRIG_SRC, 1, rd);
      expect_equal("TRIG_SRC", rd, 16'h0);
      usb_read(ADDR_TRIG_MODE, 1, rd);
      expect_equal("TRIG_MODE", rd, 16'h0);
      usb_read(ADDR_TRIG_COUNT, 1, rd);
      expect_equal("TRIG_COUNT", rd, 16'h0);
      usb_read(ADDR_ADC_STATUS, 1, rd);
      expect_equal("ADC_STATUS", rd, 16'h0);
   endtask

   task automatic readback_registers();
      logic [7:0]  val;
      logic [15:0] rd;
      roundtrip_register(ADDR_TRIG_SRC, "TRIG_SRC", 8'h0f, val);
      roundtrip_register(ADDR_TRIG_MODE, "TRIG_MODE", 8'h03, val);
      roundtrip_register(ADDR_ADC_CTRL, "ADC_CTRL", 8'h07, val);
      @(negedge clk_usb_buf);
      expect_equal("adc ctrl pins", 16'({adc_dfs_o, adc_oe_o, adc_reset_o}),
                   16'(val[2:0]));
      usb_read(8'h44, 1, rd);                // nothing mapped here
      expect_equal("unmapped 0x44", rd, 16'h0);
   endtask

   task automatic trigger_combine();
      int         rnd;
      logic [3:0] mask;
      logic [1:0] mode;
      logic [3:0] io;
      for (int cfg = 0; cfg < 4; cfg++) begin
         rnd  = $random(seed);
         mask = rnd[3:0];
         mode = rnd[5:4];
         usb_write(ADDR_TRIG_SRC, 1, {12'h0, mask});
         usb_write(ADDR_TRIG_MODE, 1, {14'h0, mode});
         for (int n = 0; n < 20; n++) begin
            rnd = $random(seed);
            io  = rnd[3:0];
            @(posedge clk_usb_buf);
            target_io_i <= io;
            repeat (2) @(posedge clk_usb_buf);
            @(negedge clk_usb_buf);
            expect_equal("trigger_o", 16'(trigger_o), 16'(trig_model(io, mask, mode)));
         end
      end
   endtask

   task automatic trigger_counter();
      int          rnd;
      int          edges;
      logic [15:0] rd;
      rnd   = $random(seed);
      edges = 3 + int'(rnd[2:0]);
      @(posedge clk_usb_buf);
      target_io_i <= 4'h0;
      usb_write(ADDR_TRIG_MODE, 1, 16'h0000);    // or mode without invert
      usb_write(ADDR_TRIG_SRC, 1, 16'h0001);     // io1 only
      usb_write(ADDR_TRIG_COUNT, 1, 16'h00a5);   // any value clears
      repeat (edges) begin
         @(posedge clk_usb_buf);
         target_io_i <= 4'h1;
         repeat (2) @(posedge clk_usb_buf);
         target_io_i <= 4'h0;
         repeat (2) @(posedge clk_usb_buf);
      end
      usb_read(ADDR_TRIG_COUNT, 1, rd);
      expect_equal("TRIG_COUNT", rd, 16'(edges));
      usb_write(ADDR_TRIG_COUNT, 1, 16'h0000);
      usb_read(ADDR_TRIG_COUNT, 1, rd);
      expect_equal("TRIG_COUNT after clear", rd, 16'h0);
   endtask

   // watches one frame and feeds pattern on sdout msb first
   task automatic capture_frame(input logic [15:0] pattern, output logic [15:0] rx,
                                output int nbits);
      logic [15:0] tx;
      logic        sclk_now;
      logic        sclk_prev;
      int          waited;
      tx        = pattern;
      rx        = '0;
      nbits     = 0;
      sclk_prev = 1'b0;
      waited    = 0;
      @(posedge clk_usb_buf);
      adc_sdout_i <= tx[15];
      tx = {tx[14:0], 1'b0};
      @(negedge clk_usb_buf);
      while (adc_sen_o !== 1'b0 && waited < 100) begin
         @(negedge clk_usb_buf);
         waited++;
      end
      if (adc_sen_o !== 1'b0) begin
         note_timeout("adc_sen_o never went low for the frame");
      end else begin
         waited = 0;
         while (adc_sen_o === 1'b0 && waited < 100) begin
            sclk_now = adc_sclk_o;
            if (sclk_now && !sclk_prev) begin       // sclk rose at the last edge
               rx = {rx[14:0], adc_sdata_o};
               nbits++;
               @(posedge clk_usb_buf);              // next sdout bit on falling sclk
               adc_sdout_i <= tx[15];
               tx = {tx[14:0], 1'b0};
            end
            sclk_prev = sclk_now;
            @(negedge clk_usb_buf);
            waited++;
         end
         if (adc_sen_o !== 1'b1) begin
            note_timeout("adc_sen_o stayed low after the frame");
         end
      end
   endtask

   // one frame, plus a second write during busy when overlap is set
   task automatic adc_frame(input logic overlap);
      int          rnd;
      int          nbits;
      logic [15:0] pattern;
      logic [15:0] frame;
      logic [15:0] rx;
      logic [15:0] rd;
      logic        extra;
      rnd     = $random(seed);
      pattern = rnd[15:0];
      rnd     = $random(seed);
      frame   = rnd[15:0];                         // adc address byte high
      extra   = 1'b0;
      fork
         capture_frame(pattern, rx, nbits);
         begin
            usb_write(ADDR_ADC_SPI, 2, {frame[7:0], frame[15:8]});
            if (overlap) begin
               usb_write(ADDR_ADC_SPI, 2, ~{frame[7:0], frame[15:8]});
            end else begin
               usb_read(ADDR_ADC_STATUS, 1, rd);   // frame still shifting
               expect_equal("ADC_STATUS busy during frame", rd, 16'h1);
            end
         end
      join
      expect_equal("adc frame bit count", 16'(nbits), 16'd16);
      expect_equal("adc_sdata_o frame", rx, frame);
      if (overlap) begin
         repeat (60) begin
            @(negedge clk_usb_buf);
            if (adc_sen_o !== 1'b1) begin
               extra = 1'b1;
            end
         end
         if (extra) begin
            failures++;
            $display("An extra ADC frame ran after the write made while busy");
         end
      end
      usb_read(ADDR_ADC_STATUS, 1, rd);
      expect_equal("ADC_STATUS busy", rd, 16'h0);
      usb_read(ADDR_ADC_SPI, 1, rd);
      expect_equal("ADC_SPI readback", rd, {8'h00, pattern[7:0]});
   endtask

   initial begin
      clk_usb_buf = 1'b0;
      arst_n_i    = 1'b0;
      usb_addr_i  = 8'h00;
      usb_data_i  = 8'h00;
      usb_alen_i  = 1'b1;
      usb_cen_i   = 1'b1;
      usb_rdn_i   = 1'b1;
      usb_wrn_i   = 1'b1;
      target_io_i = 4'h0;
      adc_sdout_i = 1'b0;
      checks      = 0;
      mismatches  = 0;
      failures    = 0;
      repeat (5) @(posedge clk_usb_buf);
      arst_n_i <= 1'b1;

      check_reset_state();
      readback_registers();
      trigger_combine();
      trigger_counter();
      adc_frame(1'b0);                     // plain frame
      adc_frame(1'b1);                     // busy lockout

      repeat (5) @(posedge clk_usb_buf);
      $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches,
               failures);
      if (mismatches == 0 && failures == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
husky_pkg.sv
usb_reg_bus.sv
reg_trigger.sv
reg_adc_ctrl.sv
husky_regs_top.sv
tb_husky_regs.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the register core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_husky_regs -o tb_husky_regs

out=$(./obj_dir/tb_husky_regs)
echo "$out"

# pass only when the testbench printed its pass line
if grep -qx "=== PASS ===" <<< "$out"; then
   exit 0
fi
exit 1
